// File: design/fact_accel_sys.sv
`timescale 1ns/1ps
`default_nettype none

module fact_accel_sys #(
    parameter int NUM_UNITS = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [soc_map_pkg::ADDR_W-1:0] addr,
    input  logic [fact_pkg::DATA_W-1:0]    wdata,
    input  logic                           we,
    input  logic                           irq_ack,
    output logic [fact_pkg::DATA_W-1:0]    rdata,
    output logic                           irq,
    output logic [1:0]                     irq_addr
);

    localparam int DW = fact_pkg::DATA_W;

    logic [NUM_UNITS-1:0][DW-1:0] unit_rd;
    logic [NUM_UNITS-1:0]         unit_we;
    logic [NUM_UNITS-1:0]         unit_done;
    logic [NUM_UNITS-1:0]         pending;
    logic [DW-1:0]                intc_rd;
    logic [1:0]                   reg_sel;

    assign intc_rd = {{(DW - NUM_UNITS){1'b0}}, pending};

    mmio_fabric #(
        .NUM_UNITS (NUM_UNITS)
    ) i_mmio_fabric (
        .addr    (addr),
        .we      (we),
        .unit_rd (unit_rd),
        .intc_rd (intc_rd),
        .unit_we (unit_we),
        .reg_sel (reg_sel),
        .rdata   (rdata)
    );

    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
        fact_unit i_fact_unit (
            .clk        (clk),
            .rst_n      (rst_n),
            .we         (unit_we[i]),
            .reg_sel    (reg_sel),
            .wdata      (wdata),
            .rd_data    (unit_rd[i]),
            .done_pulse (unit_done[i])
        );
    end

    intc #(
        .NUM_UNITS (NUM_UNITS)
    ) i_intc (
        .clk        (clk),
        .rst_n      (rst_n),
        .done_pulse (unit_done),
        .irq_ack    (irq_ack),
        .irq        (irq),
        .irq_addr   (irq_addr),
        .pending    (pending)
    );

endmodule

`default_nettype wire

// File: design/fact_counter.sv
`timescale 1ns/1ps
`default_nettype none

module fact_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  logic                     step,
    input  logic [fact_pkg::N_W-1:0] n,
    output logic [fact_pkg::N_W-1:0] count,
    output logic                     last
);

    localparam int NW = fact_pkg::N_W;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            // 0! is 1! so a zero operand starts at 1
            count <= (n == '0) ? NW'(1) : n;
        end else if (step) begin
            count <= count - NW'(1);
        end
    end

    // multiplier 2 is the final one
    // a loaded 1 falls under this too and only multiplies by 1
    assign last = (count <= NW'(2));

endmodule

`default_nettype wire

// File: design/fact_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fact_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic go,
    input  logic last,
    output logic load,
    output logic step,
    output logic busy,
    output logic done,
    output logic done_pulse
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIN
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            done_pulse <= 1'b0;
        end else begin
            state      <= state_nxt;
            // high for the single cycle right after the last multiply
            done_pulse <= (state == RUN) && last;
        end
    end

    always_comb begin
        state_nxt = state;
        load      = 1'b0;
        step      = 1'b0;
        case (state)
            IDLE, FIN: begin
                if (go) begin
                    load      = 1'b1;
                    state_nxt = RUN;
                end
            end
            RUN: begin
                // one multiply per cycle, the last one included
                step = 1'b1;
                if (last) begin
                    state_nxt = FIN;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    assign busy = (state == RUN);
    // FIN is held until the next go
    assign done = (state == FIN);

endmodule

`default_nettype wire

// File: design/fact_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module fact_datapath (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load,
    input  logic                        step,
    input  logic [fact_pkg::N_W-1:0]    count,
    output logic [fact_pkg::DATA_W-1:0] product,
    output logic                        ovf
);

    localparam int DW = fact_pkg::DATA_W;
    localparam int NW = fact_pkg::N_W;

    // full width product, upper bits only feed the overflow flag
    logic [DW+NW-1:0] full;

    assign full = product * count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product <= DW'(1);
            ovf     <= 1'b0;
        end else if (load) begin
            product <= DW'(1);
            ovf     <= 1'b0;
        end else if (step) begin
            product <= full[DW-1:0];
            // sticky once the result leaves 32 bits
            ovf     <= ovf | (|full[DW+NW-1:DW]);
        end
    end

endmodule

`default_nettype wire

// File: design/fact_pkg.sv
`default_nettype none

package fact_pkg;

    // operand width of one factorial unit
    parameter int N_W = 4;

    // bus and result width
    parameter int DATA_W = 32;

    // bit positions in the STATUS register
    parameter int ST_DONE = 0;
    parameter int ST_BUSY = 1;
    parameter int ST_ERR  = 2;

endpackage

`default_nettype wire

// File: design/fact_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fact_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  logic [1:0]                  reg_sel,
    input  logic [fact_pkg::DATA_W-1:0] wdata,
    output logic [fact_pkg::DATA_W-1:0] rd_data,
    output logic                        done_pulse
);

    localparam int DW = fact_pkg::DATA_W;
    localparam int NW = fact_pkg::N_W;

    logic [NW-1:0] n_q;
    logic [NW-1:0] count;
    logic [DW-1:0] product;
    logic [DW-1:0] status;
    logic          go;
    logic          load;
    logic          step;
    logic          last;
    logic          busy;
    logic          done;
    logic          ovf;

    // operand register, frozen during a run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n_q <= '0;
        end else if (we && (reg_sel == soc_map_pkg::REG_N) && !busy) begin
            n_q <= wdata[NW-1:0];
        end
    end

    // the FSM drops a go that arrives while busy
    assign go = we && (reg_sel == soc_map_pkg::REG_GO) && wdata[0];

    fact_ctrl i_fact_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .go         (go),
        .last       (last),
        .load       (load),
        .step       (step),
        .busy       (busy),
        .done       (done),
        .done_pulse (done_pulse)
    );

    fact_counter i_fact_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .step  (step),
        .n     (n_q),
        .count (count),
        .last  (last)
    );

    fact_datapath i_fact_datapath (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .step    (step),
        .count   (count),
        .product (product),
        .ovf     (ovf)
    );

    always_comb begin
        status                   = '0;
        status[fact_pkg::ST_DONE] = done;
        status[fact_pkg::ST_BUSY] = busy;
        status[fact_pkg::ST_ERR]  = ovf;
    end

    // GO reads back as zero
    always_comb begin
        case (reg_sel)
            soc_map_pkg::REG_N:      rd_data = DW'(n_q);
            soc_map_pkg::REG_STATUS: rd_data = status;
            soc_map_pkg::REG_RESULT: rd_data = product;
            default:                 rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/intc.sv
`timescale 1ns/1ps
`default_nettype none

module intc #(
    parameter int NUM_UNITS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_UNITS-1:0] done_pulse,
    input  logic                 irq_ack,
    output logic                 irq,
    output logic [1:0]           irq_addr,
    output logic [NUM_UNITS-1:0] pending
);

    logic [NUM_UNITS-1:0] ack_clr;
    logic [NUM_UNITS-1:0] pending_nxt;

    // lowest pending index wins, scan from the top down
    always_comb begin
        irq_addr = '0;
        for (int i = NUM_UNITS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irq_addr = 2'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            ack_clr[i] = irq_ack && (irq_addr == 2'(i));
        end
    end

    // a fresh pulse beats an ack of the same unit
    assign pending_nxt = (pending & ~ack_clr) | done_pulse;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
            irq     <= 1'b0;
        end else begin
            pending <= pending_nxt;
            irq     <= |pending_nxt;
        end
    end

endmodule

`default_nettype wire

// File: design/mmio_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_fabric #(
    parameter int NUM_UNITS = 4
) (
    input  logic [soc_map_pkg::ADDR_W-1:0]             addr,
    input  logic                                       we,
    input  logic [NUM_UNITS-1:0][fact_pkg::DATA_W-1:0] unit_rd,
    input  logic [fact_pkg::DATA_W-1:0]                intc_rd,
    output logic [NUM_UNITS-1:0]                       unit_we,
    output logic [1:0]                                 reg_sel,
    output logic [fact_pkg::DATA_W-1:0]                rdata
);

    logic       intc_sel;
    logic [1:0] unit_idx;

    assign intc_sel = addr[soc_map_pkg::INTC_SEL_BIT];
    assign unit_idx = addr[soc_map_pkg::UNIT_LSB +: 2];
    assign reg_sel  = addr[1:0];

    // one-hot strobe, nothing is writable in the intc region
    always_comb begin
        unit_we = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (we && !intc_sel && (unit_idx == 2'(i))) begin
                unit_we[i] = 1'b1;
            end
        end
    end

    // unused unit slots read as zero
    always_comb begin
        rdata = '0;
        if (intc_sel) begin
            rdata = intc_rd;
        end else begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                if (unit_idx == 2'(i)) begin
                    rdata = unit_rd[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

    // word address width of the host bus
    parameter int ADDR_W = 8;

    // register index inside one unit, address bits 1:0
    parameter logic [1:0] REG_N      = 2'd0;
    parameter logic [1:0] REG_GO     = 2'd1;
    parameter logic [1:0] REG_STATUS = 2'd2;
    parameter logic [1:0] REG_RESULT = 2'd3;

    // unit index sits in bits 3:2
    parameter int UNIT_LSB = 2;

    // set selects the interrupt controller region
    parameter int INTC_SEL_BIT = 6;

endpackage

`default_nettype wire

// File: dv/fact_accel_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fact_accel_chk #(
    parameter int NUM_UNITS = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 irq,
    input logic [1:0]           irq_addr,
    input logic [NUM_UNITS-1:0] pending,
    input logic [NUM_UNITS-1:0] done_pulse,
    input logic [NUM_UNITS-1:0] busy,
    input logic [NUM_UNITS-1:0] done
);

    // a completion shows up on irq one cycle later
    pulse_raises_irq: assert property (
        @(posedge clk) disable iff (!rst_n) (|done_pulse) |=> irq
    ) else $error("done pulse did not raise irq");

    no_busy_and_done: assert property (
        @(posedge clk) disable iff (!rst_n) (busy & done) == '0
    ) else $error("a unit is busy and done at once");

    irq_addr_pending: assert property (
        @(posedge clk) disable iff (!rst_n) irq |-> pending[irq_addr]
    ) else $error("irq_addr names a unit that is not pending");

endmodule

// per-unit state taken from the four unit instances
bind fact_accel_sys fact_accel_chk #(
    .NUM_UNITS (NUM_UNITS)
) i_fact_accel_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .irq        (irq),
    .irq_addr   (irq_addr),
    .pending    (pending),
    .done_pulse (unit_done),
    .busy       ({g_unit[3].i_fact_unit.busy, g_unit[2].i_fact_unit.busy,
                  g_unit[1].i_fact_unit.busy, g_unit[0].i_fact_unit.busy}),
    .done       ({g_unit[3].i_fact_unit.done, g_unit[2].i_fact_unit.done,
                  g_unit[1].i_fact_unit.done, g_unit[0].i_fact_unit.done})
);

`default_nettype wire

// File: dv/fact_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fact_accel_tb;

    localparam int NUM_UNITS = 4;
    localparam int AW = soc_map_pkg::ADDR_W;
    localparam int DW = fact_pkg::DATA_W;
    // about 20 runs of under 60 cycles each plus the checks around them
    localparam int MAX_CYCLES = 4000;
    localparam int POLL_LIMIT = 64;
    localparam logic [AW-1:0] INTC_ADDR = AW'(1) << soc_map_pkg::INTC_SEL_BIT;

    logic                 clk;
    logic                 rst_n;
    logic [AW-1:0]        addr;
    logic [DW-1:0]        wdata;
    logic                 we;
    logic                 irq_ack;
    logic [DW-1:0]        rdata;
    logic                 irq;
    logic [1:0]           irq_addr;
    logic [NUM_UNITS-1:0] exp_pending;
    int                   mismatch_cnt = 0;
    int                   fail_cnt = 0;
    int                   cycle_cnt = 0;

    tb_clk_gen #(
        .PERIOD_NS  (10),
        .RST_CYCLES (5)
    ) i_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fact_accel_sys #(
        .NUM_UNITS (NUM_UNITS)
    ) i_fact_accel_sys (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .wdata    (wdata),
        .we       (we),
        .irq_ack  (irq_ack),
        .rdata    (rdata),
        .irq      (irq),
        .irq_addr (irq_addr)
    );

    // expected result, err when n! needs more than 32 bits
    function automatic logic [DW-1:0] fact_ref(input logic [3:0] n, output logic err);
        logic [63:0] acc;
        acc = 64'd1;
        for (int k = 2; k <= int'(n); k++) begin
            acc = acc * 64'(k);
        end
        err = (n > 4'd12);
        return acc[DW-1:0];
    endfunction

    function automatic logic [AW-1:0] reg_addr(input int idx, input logic [1:0] sel);
        logic [AW-1:0] a;
        a = '0;
        a[soc_map_pkg::UNIT_LSB +: 2] = 2'(idx);
        a[1:0] = sel;
        return a;
    endfunction

    function automatic logic [1:0] lowest_set(input logic [NUM_UNITS-1:0] v);
        logic [1:0] idx;
        logic       found;
        idx = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (v[i] && !found) begin
                idx = 2'(i);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    task automatic bus_write(input logic [AW-1:0] a, input logic [DW-1:0] d);
        @(posedge clk);
        #1;
        addr  = a;
        wdata = d;
        we    = 1'b1;
        @(posedge clk);
        #1;
        we = 1'b0;
    endtask

    // rdata is combinational, sampled mid-cycle
    task automatic bus_read(input logic [AW-1:0] a, output logic [DW-1:0] d);
        @(posedge clk);
        #1;
        addr = a;
        we   = 1'b0;
        @(negedge clk);
        d = rdata;
    endtask

    task automatic ack_irq();
        @(posedge clk);
        #1;
        irq_ack = 1'b1;
        @(posedge clk);
        #1;
        irq_ack = 1'b0;
    endtask

    // poll STATUS until done, then compare RESULT and err
    task automatic check_unit(input int idx, input logic [3:0] n);
        logic [DW-1:0] status;
        logic [DW-1:0] result;
        logic [DW-1:0] exp_result;
        logic          exp_err;
        int            polls;
        exp_result = fact_ref(n, exp_err);
        status = '0;
        polls = 0;
        while (!status[fact_pkg::ST_DONE] && polls < POLL_LIMIT) begin
            bus_read(reg_addr(idx, soc_map_pkg::REG_STATUS), status);
            polls++;
        end
        if (!status[fact_pkg::ST_DONE]) begin
            $display("Error at %0t: unit %0d never finished n=%0d", $time, idx, n);
            fail_cnt++;
        end else begin
            exp_pending[idx] = 1'b1;
            bus_read(reg_addr(idx, soc_map_pkg::REG_RESULT), result);
            if (result !== exp_result) begin
                $display("Mismatch at %0t: unit %0d n=%0d result %0h expected %0h",
                         $time, idx, n, result, exp_result);
                mismatch_cnt++;
            end
            if (status[fact_pkg::ST_ERR] !== exp_err) begin
                $display("Mismatch at %0t: unit %0d n=%0d err %0b expected %0b",
                         $time, idx, n, status[fact_pkg::ST_ERR], exp_err);
                mismatch_cnt++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [DW-1:0] data;
        logic [3:0]    ops [NUM_UNITS];
        logic [1:0]    lowest;
        addr        = '0;
        wdata       = '0;
        we          = 1'b0;
        irq_ack     = 1'b0;
        exp_pending = '0;
        void'($urandom(27785));
        @(posedge rst_n);

        // reset values
        for (int u = 0; u < NUM_UNITS; u++) begin
            bus_read(reg_addr(u, soc_map_pkg::REG_STATUS), data);
            if (data !== '0) begin
                $display("Mismatch at %0t: unit %0d STATUS %0h after reset", $time, u, data);
                mismatch_cnt++;
            end
            bus_read(reg_addr(u, soc_map_pkg::REG_RESULT), data);
            if (data !== DW'(1)) begin
                $display("Mismatch at %0t: unit %0d RESULT %0h after reset", $time, u, data);
                mismatch_cnt++;
            end
        end
        bus_read(INTC_ADDR, data);
        if (data !== '0 || irq !== 1'b0) begin
            $display("Mismatch at %0t: pending %0h irq %0b after reset", $time, data, irq);
            mismatch_cnt++;
        end

        // every operand on unit 0
        for (int n = 0; n < 16; n++) begin
            bus_write(reg_addr(0, soc_map_pkg::REG_N), DW'(n));
            bus_write(reg_addr(0, soc_map_pkg::REG_GO), DW'(1));
            check_unit(0, 4'(n));
        end

        // all units running at once
        for (int u = 0; u < NUM_UNITS; u++) begin
            ops[u] = 4'($urandom % 16);
            bus_write(reg_addr(u, soc_map_pkg::REG_N), DW'(ops[u]));
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            bus_write(reg_addr(u, soc_map_pkg::REG_GO), DW'(1));
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            check_unit(u, ops[u]);
        end

        // drain the interrupts, lowest index first
        bus_read(INTC_ADDR, data);
        if (data !== DW'(exp_pending)) begin
            $display("Mismatch at %0t: pending %0h expected %0h", $time, data, exp_pending);
            mismatch_cnt++;
        end
        while (exp_pending != '0) begin
            lowest = lowest_set(exp_pending);
            @(negedge clk);
            if (irq !== 1'b1 || irq_addr !== lowest) begin
                $display("Mismatch at %0t: irq %0b irq_addr %0d expected unit %0d",
                         $time, irq, irq_addr, lowest);
                mismatch_cnt++;
            end
            ack_irq();
            exp_pending[lowest] = 1'b0;
            bus_read(INTC_ADDR, data);
            if (data !== DW'(exp_pending)) begin
                $display("Mismatch at %0t: pending %0h expected %0h after ack",
                         $time, data, exp_pending);
                mismatch_cnt++;
            end
        end
        @(negedge clk);
        if (irq !== 1'b0) begin
            $display("Mismatch at %0t: irq still high after the last ack", $time);
            mismatch_cnt++;
        end

        // writes during a run are dropped
        bus_write(reg_addr(2, soc_map_pkg::REG_N), DW'(10));
        bus_write(reg_addr(2, soc_map_pkg::REG_GO), DW'(1));
        bus_write(reg_addr(2, soc_map_pkg::REG_N), DW'(3));
        bus_write(reg_addr(2, soc_map_pkg::REG_GO), DW'(1));
        check_unit(2, 4'd10);
        bus_read(reg_addr(2, soc_map_pkg::REG_N), data);
        if (data !== DW'(10)) begin
            $display("Mismatch at %0t: unit 2 N reads %0d expected 10", $time, data);
            mismatch_cnt++;
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release lines up with the stimulus offset
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: files.f
design/soc_map_pkg.sv
design/fact_pkg.sv
design/fact_ctrl.sv
design/fact_counter.sv
design/fact_datapath.sv
design/fact_unit.sv
design/mmio_fabric.sv
design/intc.sv
design/fact_accel_sys.sv
dv/tb_clk_gen.sv
dv/fact_accel_chk.sv
dv/fact_accel_tb.sv

// File: run.sh
#!/bin/sh
# build and run the factorial accelerator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fact_accel_tb -f files.f -o fact_accel_sim \
    && ./obj_dir/fact_accel_sim | tee /dev/stderr \
    | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
